/* source/scroll_pkg.sv */
package scroll_pkg;

    // pixel is {palette[4:0], color[3:0]}
    parameter int pxl_w = 9;
    parameter logic [pxl_w-1:0] blank_pxl = '1; // blank or transparent

    parameter int vram_aw = 16; // word address
    parameter int rom_aw  = 23; // word address, full 32-bit words

    parameter int line_w   = 512; // pixels per bank
    parameter int map_cols = 64;  // tiles per map row

    // layer n uses 8 << n pixel tiles
    parameter int base_tile_sh = 3;

    typedef enum logic [1:0] {
        seq_idle,
        seq_launch,
        seq_wait_done
    } seq_state_e;

    typedef enum logic [2:0] {
        tile_idle,
        tile_next_pixel,
        tile_fetch_vram,
        tile_fetch_rom,
        tile_write
    } tile_state_e;

endpackage

/* source/scroll_line_buf.sv */
`timescale 1ns/1ps

module scroll_line_buf (
    input  logic                                   clk,
    input  logic                                   wr,
    input  logic [$clog2(2*scroll_pkg::line_w)-1:0] wr_addr,
    input  logic [scroll_pkg::pxl_w-1:0]            wr_data,
    input  logic [$clog2(2*scroll_pkg::line_w)-1:0] rd_addr,
    output logic [scroll_pkg::pxl_w-1:0]            rd_data
);
    import scroll_pkg::*;

    // two banks, the msb of each address picks one
    logic [pxl_w-1:0] mem [2*line_w];

    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

endmodule

/* source/scroll_pixel_out.sv */
`timescale 1ns/1ps

module scroll_pixel_out #(
    parameter int layers = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [8:0]                         hdump,
    input  logic [layers*scroll_pkg::pxl_w-1:0] buf_pxl,
    output logic [layers*scroll_pkg::pxl_w-1:0] scr_pxl
);
    import scroll_pkg::*;

    logic [8:0] hdump_q; // matches the buffer read latency
    logic       active;

    // visible columns 64 to 447
    assign active = hdump_q >= 9'd64 && hdump_q < 9'd448;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump_q <= 9'd0;
            scr_pxl <= {layers{blank_pxl}};
        end else begin
            hdump_q <= hdump;
            for (int i = 0; i < layers; i++) begin
                scr_pxl[i*pxl_w +: pxl_w] <= active ? buf_pxl[i*pxl_w +: pxl_w] : blank_pxl;
            end
        end
    end

endmodule

/* source/scroll_sequencer.sv */
`timescale 1ns/1ps

module scroll_sequencer #(
    parameter int layers = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 layer_done,
    input  logic [layers*16-1:0] vram_base,
    input  logic [layers*16-1:0] hpos,
    input  logic [layers*16-1:0] vpos,
    output logic [1:0]           cur_layer,
    output logic [15:0]          cur_base,
    output logic [15:0]          cur_hpos,
    output logic [15:0]          cur_vpos,
    output logic                 layer_start,
    output logic                 line_done
);
    import scroll_pkg::*;

    seq_state_e state;
    logic       last;
    logic       advance;
    logic       load;
    logic [1:0] sel;

    assign last = cur_layer == 2'(layers - 1);
    // a done pulse left over from an aborted layer can coincide with layer_start
    assign advance = state == seq_wait_done && layer_done && !layer_start;
    assign load = start || (advance && !last);
    assign sel = start ? 2'd0 : cur_layer + 2'd1; // layer whose registers get loaded

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= seq_idle;
            cur_layer   <= 2'd0;
            layer_start <= 1'b0;
            line_done   <= 1'b0;
        end else begin
            layer_start <= 1'b0;
            line_done   <= 1'b0;
            if (start) begin // also restarts a busy line
                state     <= seq_launch;
                cur_layer <= 2'd0;
            end else begin
                case (state)
                    seq_launch: begin
                        layer_start <= 1'b1; // registers settled last cycle
                        state       <= seq_wait_done;
                    end
                    seq_wait_done: begin
                        if (advance) begin
                            if (last) begin
                                line_done <= 1'b1;
                                state     <= seq_idle;
                            end else begin
                                cur_layer <= sel;
                                state     <= seq_launch;
                            end
                        end
                    end
                    default: state <= seq_idle;
                endcase
            end
        end
    end

    // scroll registers of the layer being drawn
    always_ff @(posedge clk) begin
        if (load) begin
            cur_base <= vram_base[sel*16 +: 16];
            cur_hpos <= hpos[sel*16 +: 16];
            cur_vpos <= vpos[sel*16 +: 16];
        end
    end

endmodule

/* source/scroll_tilemap.sv */
`timescale 1ns/1ps

module scroll_tilemap (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          layer_start,
    input  logic [1:0]                    cur_layer,
    input  logic [15:0]                   cur_base,
    input  logic [15:0]                   cur_hpos,
    input  logic [15:0]                   cur_vpos,
    input  logic [8:0]                    vrender,
    output logic                          layer_done,
    output logic [scroll_pkg::vram_aw-1:0] vram_addr,
    output logic                          vram_cs,
    input  logic [15:0]                   vram_data,
    input  logic                          vram_ok,
    output logic [scroll_pkg::rom_aw-1:0]  rom_addr,
    output logic                          rom_cs,
    input  logic [31:0]                   rom_data,
    input  logic                          rom_ok,
    output logic [8:0]                    buf_addr,
    output logic [scroll_pkg::pxl_w-1:0]  buf_data,
    output logic                          buf_wr
);
    import scroll_pkg::*;

    tile_state_e state;
    logic [8:0]  x;
    logic        go; // start held back by an open memory request
    logic [4:0]  tile_pal;
    logic [10:0] tile_code;
    logic [31:0] rom_word;

    logic [2:0]  tsh;     // log2 of tile size
    logic [3:0]  code_sh; // log2 of rom words per tile
    logic [15:0] mask;
    logic [15:0] sx;
    logic [15:0] sy;
    logic [15:0] sx_nxt;
    logic [15:0] sx_tile;
    logic [15:0] sy_tile;
    logic [vram_aw-1:0] vram_addr_c;
    logic [rom_aw-1:0]  rom_addr_c;
    logic [3:0]  color;
    logic        restart;
    logic        last_x;
    logic        issue_vram;
    logic        issue_rom;

    assign tsh     = 3'(base_tile_sh) + {1'b0, cur_layer};
    assign code_sh = 4'(base_tile_sh) + {1'b0, cur_layer, 1'b0};
    assign mask    = (16'd1 << tsh) - 16'd1;

    assign sx      = 16'(x) + cur_hpos; // wraps at 2^16
    assign sy      = 16'(vrender) + cur_vpos;
    assign sx_nxt  = sx + 16'd1;
    assign sx_tile = sx >> tsh;
    assign sy_tile = sy >> tsh;

    // map is 64x64 tiles, row major
    assign vram_addr_c = cur_base
                       + vram_aw'(sy_tile[5:0]) * vram_aw'(map_cols)
                       + vram_aw'(sx_tile[5:0]);

    assign rom_addr_c = (rom_aw'(tile_code) << code_sh)
                      + (rom_aw'(sy & mask) << cur_layer)
                      + rom_aw'((sx & mask) >> 3);

    assign restart    = (go || layer_start) && !vram_cs && !rom_cs;
    assign last_x     = x == 9'(line_w - 1);
    assign issue_vram = state == tile_fetch_vram && !vram_cs && !restart;
    assign issue_rom  = state == tile_fetch_rom && !rom_cs && !restart;

    // nibble k of the rom word is pixel k of the 8-pixel group
    assign color    = rom_word[{sx[2:0], 2'b00} +: 4];
    assign buf_wr   = state == tile_write;
    assign buf_addr = x;
    assign buf_data = (color == 4'hf) ? blank_pxl : {tile_pal, color};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= tile_idle;
            x          <= 9'd0;
            go         <= 1'b0;
            vram_cs    <= 1'b0;
            rom_cs     <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            layer_done <= 1'b0;
            if (restart) begin
                x     <= 9'd0;
                go    <= 1'b0;
                state <= tile_next_pixel;
            end else begin
                if (layer_start)
                    go <= 1'b1;
                case (state)
                    tile_next_pixel: begin
                        if (x == 9'd0 || (sx & mask) == 16'd0)
                            state <= tile_fetch_vram;
                        else if (sx[2:0] == 3'd0)
                            state <= tile_fetch_rom;
                        else
                            state <= tile_write;
                    end
                    tile_fetch_vram: begin
                        if (issue_vram) begin
                            vram_cs <= 1'b1;
                        end else if (vram_ok) begin
                            vram_cs <= 1'b0;
                            state   <= tile_fetch_rom; // new tile needs its row too
                        end
                    end
                    tile_fetch_rom: begin
                        if (issue_rom) begin
                            rom_cs <= 1'b1;
                        end else if (rom_ok) begin
                            rom_cs <= 1'b0;
                            state  <= tile_write;
                        end
                    end
                    tile_write: begin
                        if (last_x) begin
                            layer_done <= 1'b1; // last pixel written this cycle
                            state      <= tile_idle;
                        end else begin
                            x <= x + 9'd1;
                            if (sx_nxt[2:0] == 3'd0)
                                state <= tile_next_pixel;
                        end
                    end
                    default: state <= tile_idle;
                endcase
            end
        end
    end

    // request addresses and fetched data
    always_ff @(posedge clk) begin
        if (issue_vram)
            vram_addr <= vram_addr_c;
        if (issue_rom)
            rom_addr <= rom_addr_c;
        if (state == tile_fetch_vram && vram_cs && vram_ok) begin
            tile_pal  <= vram_data[15:11];
            tile_code <= vram_data[10:0];
        end
        if (state == tile_fetch_rom && rom_cs && rom_ok)
            rom_word <= rom_data;
    end

endmodule

/* source/scroll_render.sv */
`timescale 1ns/1ps

module scroll_render #(
    parameter int layers = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [8:0]                         vrender, // one line ahead of vdump
    input  logic [8:0]                         vdump,
    input  logic [8:0]                         hdump,
    input  logic [layers*16-1:0]               vram_base,
    input  logic [layers*16-1:0]               hpos,
    input  logic [layers*16-1:0]               vpos,
    input  logic                               start,
    output logic [scroll_pkg::vram_aw-1:0]     vram_addr,
    output logic                               vram_cs,
    input  logic [15:0]                        vram_data,
    input  logic                               vram_ok,
    output logic [scroll_pkg::rom_aw-1:0]      rom_addr,
    output logic                               rom_cs,
    input  logic [31:0]                        rom_data,
    input  logic                               rom_ok,
    output logic [layers*scroll_pkg::pxl_w-1:0] scr_pxl,
    output logic                               line_done
);
    import scroll_pkg::*;

    localparam int buf_aw = $clog2(2*line_w);

    logic [1:0]                 cur_layer;
    logic [15:0]                cur_base;
    logic [15:0]                cur_hpos;
    logic [15:0]                cur_vpos;
    logic                       layer_start;
    logic                       layer_done;
    logic [8:0]                 buf_addr;
    logic [pxl_w-1:0]           buf_data;
    logic                       buf_wr;
    logic [buf_aw-1:0]          wr_addr;
    logic [buf_aw-1:0]          rd_addr;
    logic [layers*pxl_w-1:0]    buf_pxl;

    assign wr_addr = {vdump[0], buf_addr};  // bank being drawn
    assign rd_addr = {~vdump[0], hdump};    // bank on screen

    scroll_sequencer #(.layers(layers)) u_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .layer_done  (layer_done),
        .vram_base   (vram_base),
        .hpos        (hpos),
        .vpos        (vpos),
        .cur_layer   (cur_layer),
        .cur_base    (cur_base),
        .cur_hpos    (cur_hpos),
        .cur_vpos    (cur_vpos),
        .layer_start (layer_start),
        .line_done   (line_done)
    );

    scroll_tilemap u_tilemap (
        .clk         (clk),
        .rst         (rst),
        .layer_start (layer_start),
        .cur_layer   (cur_layer),
        .cur_base    (cur_base),
        .cur_hpos    (cur_hpos),
        .cur_vpos    (cur_vpos),
        .vrender     (vrender),
        .layer_done  (layer_done),
        .vram_addr   (vram_addr),
        .vram_cs     (vram_cs),
        .vram_data   (vram_data),
        .vram_ok     (vram_ok),
        .rom_addr    (rom_addr),
        .rom_cs      (rom_cs),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .buf_addr    (buf_addr),
        .buf_data    (buf_data),
        .buf_wr      (buf_wr)
    );

    for (genvar i = 0; i < layers; i++) begin : g_line
        logic wr_en;

        assign wr_en = buf_wr && cur_layer == 2'(i); // only the active layer's buffer

        scroll_line_buf u_buf (
            .clk     (clk),
            .wr      (wr_en),
            .wr_addr (wr_addr),
            .wr_data (buf_data),
            .rd_addr (rd_addr),
            .rd_data (buf_pxl[i*pxl_w +: pxl_w])
        );
    end

    scroll_pixel_out #(.layers(layers)) u_pxl (
        .clk     (clk),
        .rst     (rst),
        .hdump   (hdump),
        .buf_pxl (buf_pxl),
        .scr_pxl (scr_pxl)
    );

endmodule

/* bench/scroll_mem_model.sv */
`timescale 1ns/1ps

module scroll_mem_model (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [scroll_pkg::vram_aw-1:0] vram_addr,
    input  logic                           vram_cs,
    output logic [15:0]                    vram_data,
    output logic                           vram_ok,
    input  logic [scroll_pkg::rom_aw-1:0]  rom_addr,
    input  logic                           rom_cs,
    output logic [31:0]                    rom_data,
    output logic                           rom_ok
);
    logic       vram_busy;
    logic       rom_busy;
    logic [1:0] vram_cnt;
    logic [1:0] rom_cnt;

    // latency is 1 plus the low two address bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vram_busy <= 1'b0;
            rom_busy  <= 1'b0;
            vram_ok   <= 1'b0;
            rom_ok    <= 1'b0;
            vram_data <= '0;
            rom_data  <= '0;
        end else begin
            vram_ok <= 1'b0;
            rom_ok  <= 1'b0;
            if (!vram_busy && vram_cs && !vram_ok) begin // ok cycle still shows old cs
                vram_busy <= 1'b1;
                vram_cnt  <= vram_addr[1:0];
            end else if (vram_busy && vram_cnt == 2'd0) begin
                vram_busy <= 1'b0;
                vram_ok   <= 1'b1;
                vram_data <= (vram_addr * 16'h9e37) ^ 16'h5a5a;
            end else if (vram_busy) begin
                vram_cnt <= vram_cnt - 2'd1;
            end
            if (!rom_busy && rom_cs && !rom_ok) begin
                rom_busy <= 1'b1;
                rom_cnt  <= rom_addr[1:0];
            end else if (rom_busy && rom_cnt == 2'd0) begin
                rom_busy <= 1'b0;
                rom_ok   <= 1'b1;
                rom_data <= {rom_addr, ~rom_addr[8:0]};
            end else if (rom_busy) begin
                rom_cnt <= rom_cnt - 2'd1;
            end
        end
    end

endmodule

/* bench/scroll_render_chk.sv */
`timescale 1ns/1ps

module scroll_render_chk (
    input logic                           clk,
    input logic                           rst,
    input logic                           start,
    input logic                           line_done,
    input logic                           buf_wr,
    input logic                           vram_cs,
    input logic                           vram_ok,
    input logic [scroll_pkg::vram_aw-1:0] vram_addr,
    input logic                           rom_cs,
    input logic                           rom_ok,
    input logic [scroll_pkg::rom_aw-1:0]  rom_addr
);
    logic busy; // a line is being drawn
    int   fails = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            busy <= 1'b0;
        else if (start)
            busy <= 1'b1;
        else if (line_done)
            busy <= 1'b0;
    end

    vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr))
        else begin
            $error("vram request dropped or moved before vram_ok");
            fails++;
        end

    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            $error("rom request dropped or moved before rom_ok");
            fails++;
        end

    // one single-cycle line_done per start
    done_pulse: assert property (@(posedge clk) disable iff (rst) line_done |-> busy)
        else begin
            $error("line_done without a pending start or held for more than one cycle");
            fails++;
        end

    idle_write: assert property (@(posedge clk) disable iff (rst) buf_wr |-> busy)
        else begin
            $error("line buffer written while no line is being drawn");
            fails++;
        end

endmodule

/* bench/scroll_render_tb.sv */
`timescale 1ns/1ps

module scroll_render_tb;
    import scroll_pkg::*;

    localparam int n_layers = 3;
    localparam int n_rows   = 6;
    localparam int timeout_cycles = n_rows * (3 * 512 * 10 + 600);

    logic                        clk;
    logic                        rst;
    logic                        start;
    logic [8:0]                  vrender;
    logic [8:0]                  vdump;
    logic [8:0]                  hdump;
    logic [n_layers*16-1:0]      vram_base;
    logic [n_layers*16-1:0]      hpos;
    logic [n_layers*16-1:0]      vpos;
    logic [vram_aw-1:0]          vram_addr;
    logic                        vram_cs;
    logic [15:0]                 vram_data;
    logic                        vram_ok;
    logic [rom_aw-1:0]           rom_addr;
    logic                        rom_cs;
    logic [31:0]                 rom_data;
    logic                        rom_ok;
    logic [n_layers*pxl_w-1:0]   scr_pxl;
    logic                        line_done;

    // stimulus table with layer 0 in the low 16 bits of each bus
    string       row_name [n_rows];
    logic [8:0]  row_vr   [n_rows];
    logic [47:0] row_base [n_rows];
    logic [47:0] row_hpos [n_rows];
    logic [47:0] row_vpos [n_rows];

    logic [31:0] lfsr;
    int cycles = 0;
    int done_count = 0;
    int checks = 0;
    int errors = 0;

    scroll_render #(.layers(n_layers)) UUT (.*);

    scroll_mem_model u_mem (.*);

    bind scroll_render scroll_render_chk u_chk (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (line_done)
            done_count <= done_count + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, line_done did not arrive", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin // one lfsr step per bit
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // rendering rule applied to the computed vram and rom contents
    function automatic logic [pxl_w-1:0] ref_pixel(input int n, input int x, input int r);
        int t;
        int sx;
        int sy;
        logic [15:0] vaddr;
        logic [15:0] vword;
        logic [22:0] raddr;
        logic [31:0] rword;
        logic [3:0]  color;
        t     = 8 << n;
        sx    = (x + row_hpos[r][n*16 +: 16]) % 65536;
        sy    = (row_vr[r] + row_vpos[r][n*16 +: 16]) % 65536;
        vaddr = row_base[r][n*16 +: 16] + 16'((sy / t) % 64 * 64 + (sx / t) % 64);
        vword = (vaddr * 16'h9e37) ^ 16'h5a5a;
        raddr = 23'(vword[10:0] * t * t / 8 + (sy % t) * (t / 8) + (sx % t) / 8);
        rword = {raddr, ~raddr[8:0]};
        color = rword[(sx % 8) * 4 +: 4];
        if (x < 64 || x > 447 || color == 4'hf)
            return '1;
        return {vword[15:11], color};
    endfunction

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic load_table();
        row_name[0] = "zero_scroll";
        row_vr[0]   = 9'd16;
        row_base[0] = {16'h2000, 16'h1000, 16'h0000};
        row_hpos[0] = '0;
        row_vpos[0] = '0;
        row_name[1] = "unaligned";
        row_vr[1]   = 9'd37;
        row_base[1] = row_base[0];
        row_hpos[1] = {16'd3, 16'd6, 16'd21};
        row_vpos[1] = {16'd5, 16'd22, 16'd9};
        row_name[2] = "wrapping";
        row_vr[2]   = 9'd200;
        row_base[2] = {16'hfff0, 16'h3c00, 16'hf800};
        row_hpos[2] = {16'hfffd, 16'hfff3, 16'hffe5};
        row_vpos[2] = {16'hfffe, 16'hfff9, 16'hff40};
        row_name[3] = "zero_scroll_repeat"; // same line in the other bank
        row_vr[3]   = row_vr[0];
        row_base[3] = row_base[0];
        row_hpos[3] = '0;
        row_vpos[3] = '0;
        for (int r = 4; r < n_rows; r++) begin
            row_name[r] = $sformatf("random_%0d", r - 4);
            row_vr[r]   = 9'(rand_bits(9));
            row_base[r] = {16'(rand_bits(16)), 16'(rand_bits(16)), 16'(rand_bits(16))};
            row_hpos[r] = {16'(rand_bits(16)), 16'(rand_bits(16)), 16'(rand_bits(16))};
            row_vpos[r] = {16'(rand_bits(16)), 16'(rand_bits(16)), 16'(rand_bits(16))};
        end
    endtask

    // sweeps hdump over the line and checks each result 2 cycles later
    task automatic check_sweep(input int r);
        logic [pxl_w-1:0] exp;
        logic [pxl_w-1:0] got;
        for (int i = 0; i <= 512; i++) begin
            if (i < 512)
                hdump = 9'(i);
            tick();
            for (int n = 0; n < n_layers && i > 0; n++) begin
                exp = ref_pixel(n, i - 1, r);
                got = scr_pxl[n*pxl_w +: pxl_w];
                checks++;
                assert (got === exp) else begin
                    $display("Fail %s layer %0d hdump %0d: expected %h, actual %h",
                             row_name[r], n, i - 1, exp, got);
                    errors++;
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        int err0;
        err0      = errors;
        vrender   = row_vr[r];
        vdump     = {8'd0, r[0]}; // rows alternate banks
        vram_base = row_base[r];
        hpos      = row_hpos[r];
        vpos      = row_vpos[r];
        start     = 1'b1;
        tick();
        start = 1'b0;
        while (done_count < r + 1)
            tick();
        if (r > 0)
            check_sweep(r - 1); // screen still shows the previous line
        vdump = {8'd0, ~r[0]};
        check_sweep(r);
        assert (done_count == r + 1) else begin
            $display("line_done came %0d times for %s, expected once", done_count - r, row_name[r]);
            errors++;
        end
        $display("test %s: %0d errors", row_name[r], errors - err0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        vrender   = '0;
        vdump     = '0;
        hdump     = '0;
        vram_base = '0;
        hpos      = '0;
        vpos      = '0;
        lfsr      = 32'hf3c4;
        load_table();
        repeat (2) @(posedge clk);
        #5;
        checks++;
        assert (scr_pxl === {n_layers{blank_pxl}}) else begin
            $display("Fail reset: expected %h, actual %h", {n_layers{blank_pxl}}, scr_pxl);
            errors++;
        end
        checks++;
        assert (vram_cs === 1'b0 && rom_cs === 1'b0 && line_done === 1'b0) else begin
            $display("memory request or line_done active during reset");
            errors++;
        end
        rst = 1'b0;
        for (int i = 0; i < 3; i++) begin // blank after reset outside the window
            tick();
            checks++;
            assert (scr_pxl === {n_layers{blank_pxl}}) else begin
                $display("Fail reset: expected %h, actual %h", {n_layers{blank_pxl}}, scr_pxl);
                errors++;
            end
        end
        $display("test reset: %0d errors", errors);
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        errors += UUT.u_chk.fails;
        $display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
                 n_rows + 1, checks, UUT.u_chk.fails, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* scroll_render.f */
source/scroll_pkg.sv
source/scroll_line_buf.sv
source/scroll_pixel_out.sv
source/scroll_sequencer.sv
source/scroll_tilemap.sv
source/scroll_render.sv
bench/scroll_mem_model.sv
bench/scroll_render_chk.sv
bench/scroll_render_tb.sv

/* Bender.yml */
package:
  name: scroll_render

sources:
  - source/scroll_pkg.sv
  - source/scroll_line_buf.sv
  - source/scroll_pixel_out.sv
  - source/scroll_sequencer.sv
  - source/scroll_tilemap.sv
  - source/scroll_render.sv
  - target: simulation
    files:
      - bench/scroll_mem_model.sv
      - bench/scroll_render_chk.sv
      - bench/scroll_render_tb.sv
